/* include/kv_db_config.svh */
`ifndef KV_DB_CONFIG_SVH
`define KV_DB_CONFIG_SVH

// ==============================
// Key-value store dimensions
// ==============================

// Key width, also the table address width
`define KV_DB_KEY_W 8

// Stored value width
`define KV_DB_VALUE_W 32

// Number of table entries, one per key
`define KV_DB_DEPTH (1 << `KV_DB_KEY_W)

// Keys and values as seen on the controller ports
`define KV_DB_KEY_T logic [`KV_DB_KEY_W-1:0]
`define KV_DB_VALUE_T logic [`KV_DB_VALUE_W-1:0]

`endif

/* kv_db.f */
+incdir+include
rtl/db_pkg.sv
rtl/db_store_pkg.sv
rtl/db_prio_arb.sv
rtl/db_store.sv
rtl/db_top.sv
sim/db_assert.sv
sim/db_tb.sv

/* rtl/db_pkg.sv */
`default_nettype none

`include "kv_db_config.svh"

package db_pkg;

    // ==============================
    // Commands and status codes
    // ==============================

    // Commands a controller can issue
    typedef enum logic [2:0] {
        COMMAND_NOP   = 3'd0,
        COMMAND_GET   = 3'd1,
        COMMAND_SET   = 3'd2,
        COMMAND_UNSET = 3'd3,
        COMMAND_CLEAR = 3'd4
    } command_t;

    // Completion status returned with ack
    typedef enum logic [1:0] {
        STATUS_OK          = 2'd0,
        STATUS_ERROR       = 2'd1,
        STATUS_UNSPECIFIED = 2'd2
    } status_t;

    // ==============================
    // Port structs
    // ==============================

    // Controller to store, 44 bits
    typedef struct packed {
        logic          req;
        command_t      command;
        `KV_DB_KEY_T   key;
        `KV_DB_VALUE_T set_value;
    } db_req_t;

    // Store to controller, 36 bits
    // Payload fields only mean something while ack is high
    typedef struct packed {
        logic          ack;
        status_t       status;
        logic          valid;
        `KV_DB_VALUE_T get_value;
    } db_resp_t;

endpackage : db_pkg

`default_nettype wire

/* rtl/db_prio_arb.sv */
`timescale 1ns/100ps
`default_nettype none

module db_prio_arb (
    input  wire logic             clk,
    input  wire logic             srst,

    // High-priority controller port
    input  wire db_pkg::db_req_t  req_hi,
    output      logic             rdy_hi,
    output      db_pkg::db_resp_t resp_hi,

    // Low-priority controller port
    input  wire db_pkg::db_req_t  req_lo,
    output      logic             rdy_lo,
    output      db_pkg::db_resp_t resp_lo,

    // Towards the store
    output      db_pkg::db_req_t  store_req,
    input  wire logic             store_rdy,
    input  wire db_pkg::db_resp_t store_resp
);

    // ==============================
    // Selection state
    // ==============================

    // Selection encoding: 0 picks the high port, 1 the low port
    logic sel_lo;
    logic sel_lo_reg;
    logic sel_req;
    logic req_pending;

    // Request level of whichever port is currently selected
    assign sel_req = sel_lo ? req_lo.req : req_hi.req;

    // Open transaction context
    // Set once the selected port asks, held until the store acks
    always_ff @(posedge clk) begin
        if (srst) begin
            req_pending <= 1'b0;
        end else if (store_resp.ack) begin
            req_pending <= 1'b0;
        end else if (sel_req) begin
            req_pending <= 1'b1;
        end
    end

    // Strict priority while nothing is open, otherwise keep the owner
    always_comb begin
        sel_lo = sel_lo_reg;
        if (!req_pending) begin
            sel_lo = !req_hi.req;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            sel_lo_reg <= 1'b0;
        end else begin
            sel_lo_reg <= sel_lo;
        end
    end

    // ==============================
    // Request mux, response demux
    // ==============================

    assign store_req = sel_lo ? req_lo : req_hi;

    // Only the owner sees rdy
    assign rdy_hi = store_rdy && !sel_lo;
    assign rdy_lo = store_rdy && sel_lo;

    // Payload goes to both ports, ack only to the owner
    always_comb begin
        resp_hi     = store_resp;
        resp_lo     = store_resp;
        resp_hi.ack = store_resp.ack && !sel_lo;
        resp_lo.ack = store_resp.ack && sel_lo;
    end

endmodule : db_prio_arb

`default_nettype wire

/* rtl/db_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_db_config.svh"

module db_store (
    input  wire logic             clk,
    input  wire logic             srst,

    // Request side, already arbitrated
    input  wire db_pkg::db_req_t  db_req,
    output      logic             rdy,
    output      db_pkg::db_resp_t db_resp
);

    // ==============================
    // Table and control state
    // ==============================

    db_store_pkg::entry_t       entries [`KV_DB_DEPTH];
    db_store_pkg::entry_t       rd_entry;

    db_store_pkg::store_state_t state;
    logic                       init_run;
    logic [`KV_DB_KEY_W-1:0]    clr_addr;
    logic                       sweeping;
    logic                       accept;

    // Write port
    logic                       wr_en;
    logic [`KV_DB_KEY_W-1:0]    wr_addr;
    db_store_pkg::entry_t       wr_data;

    // Registered response
    logic                       resp_ack;
    db_pkg::status_t            resp_status;
    logic                       resp_valid;
    `KV_DB_VALUE_T              resp_value;

    // Ready only when idle and the power-up wipe has finished
    assign rdy      = (state == db_store_pkg::IDLE) && !init_run;
    assign accept   = db_req.req && rdy;
    assign sweeping = init_run || (state == db_store_pkg::CLEAR_RUN);

    assign rd_entry = entries[db_req.key];

    // ==============================
    // Control FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (srst) begin
            state    <= db_store_pkg::IDLE;
            init_run <= 1'b1;
            clr_addr <= '0;
            resp_ack <= 1'b0;
        end else begin
            resp_ack <= 1'b0;

            // Sweep counter wraps back to zero after the last entry
            if (sweeping) begin
                clr_addr <= clr_addr + 1'b1;
            end

            // Wipe after reset ends silently, no ack
            if (init_run && (clr_addr == '1)) begin
                init_run <= 1'b0;
            end

            case (state)
                db_store_pkg::IDLE: begin
                    if (accept) begin
                        if (db_req.command == db_pkg::COMMAND_CLEAR) begin
                            state <= db_store_pkg::CLEAR_RUN;
                        end else begin
                            state    <= db_store_pkg::RESPOND;
                            resp_ack <= 1'b1;
                        end
                    end
                end
                db_store_pkg::RESPOND: begin
                    state <= db_store_pkg::IDLE;
                end
                db_store_pkg::CLEAR_RUN: begin
                    // Last entry cleared this cycle, ack in the next one
                    if (clr_addr == '1) begin
                        state    <= db_store_pkg::RESPOND;
                        resp_ack <= 1'b1;
                    end
                end
                default: begin
                    state <= db_store_pkg::IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Table write port
    // ==============================

    // Sweep and accepted commands never overlap, rdy is low while sweeping
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = db_req.key;
        wr_data = '0;
        if (sweeping) begin
            wr_en   = 1'b1;
            wr_addr = clr_addr;
        end else if (accept) begin
            case (db_req.command)
                db_pkg::COMMAND_SET: begin
                    wr_en         = 1'b1;
                    wr_data.valid = 1'b1;
                    wr_data.value = db_req.set_value;
                end
                db_pkg::COMMAND_UNSET: begin
                    wr_en = 1'b1;
                end
                default: begin
                    wr_en = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_addr] <= wr_data;
        end
    end

    // ==============================
    // Response payload
    // ==============================

    // Captured at acceptance, held through a clear walk
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_status <= db_pkg::STATUS_OK;
            resp_valid  <= 1'b0;
            resp_value  <= '0;
            case (db_req.command)
                db_pkg::COMMAND_GET: begin
                    resp_valid <= rd_entry.valid;
                    resp_value <= rd_entry.valid ? rd_entry.value : '0;
                end
                db_pkg::COMMAND_SET,
                db_pkg::COMMAND_UNSET,
                db_pkg::COMMAND_CLEAR: begin
                    resp_status <= db_pkg::STATUS_OK;
                end
                default: begin
                    resp_status <= db_pkg::STATUS_ERROR;
                end
            endcase
        end
    end

    assign db_resp.ack       = resp_ack;
    assign db_resp.status    = resp_status;
    assign db_resp.valid     = resp_valid;
    assign db_resp.get_value = resp_value;

endmodule : db_store

`default_nettype wire

/* rtl/db_store_pkg.sv */
`default_nettype none

`include "kv_db_config.svh"

package db_store_pkg;

    // ==============================
    // Store control FSM
    // ==============================

    // IDLE accepts, RESPOND drives ack, CLEAR_RUN sweeps the table
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        RESPOND   = 2'd1,
        CLEAR_RUN = 2'd2
    } store_state_t;

    // ==============================
    // Table layout
    // ==============================

    // One table slot, 33 bits
    typedef struct packed {
        logic          valid;
        `KV_DB_VALUE_T value;
    } entry_t;

endpackage : db_store_pkg

`default_nettype wire

/* rtl/db_top.sv */
`timescale 1ns/100ps
`default_nettype none

module db_top (
    input  wire logic             clk,
    input  wire logic             srst,

    // High-priority controller
    input  wire db_pkg::db_req_t  req_hi,
    output      logic             rdy_hi,
    output      db_pkg::db_resp_t resp_hi,

    // Low-priority controller
    input  wire db_pkg::db_req_t  req_lo,
    output      logic             rdy_lo,
    output      db_pkg::db_resp_t resp_lo
);

    // ==============================
    // Arbiter to store link
    // ==============================

    db_pkg::db_req_t  store_req;
    logic             store_rdy;
    db_pkg::db_resp_t store_resp;

    // Strict priority in front, high port wins when idle
    db_prio_arb i_arb (
        .clk        ( clk ),
        .srst       ( srst ),
        .req_hi     ( req_hi ),
        .rdy_hi     ( rdy_hi ),
        .resp_hi    ( resp_hi ),
        .req_lo     ( req_lo ),
        .rdy_lo     ( rdy_lo ),
        .resp_lo    ( resp_lo ),
        .store_req  ( store_req ),
        .store_rdy  ( store_rdy ),
        .store_resp ( store_resp )
    );

    // Single direct-mapped table
    db_store i_store (
        .clk     ( clk ),
        .srst    ( srst ),
        .db_req  ( store_req ),
        .rdy     ( store_rdy ),
        .db_resp ( store_resp )
    );

endmodule : db_top

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the kv_db testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module db_tb -f kv_db.f -o db_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/db_tb_sim 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* sim/db_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module db_assert (
    input wire logic             clk,
    input wire logic             srst,
    input wire db_pkg::db_req_t  req_hi,
    input wire db_pkg::db_req_t  req_lo,
    input wire logic             rdy_hi,
    input wire logic             rdy_lo,
    input wire db_pkg::db_resp_t resp_hi,
    input wire db_pkg::db_resp_t resp_lo,
    input wire logic             store_rdy,
    input wire db_pkg::db_resp_t store_resp
);

    // ==============================
    // Port protocol
    // ==============================

    // Ack reaches one port at a time
    assert property (@(posedge clk) disable iff (srst)
        !(resp_hi.ack && resp_lo.ack))
        else $error("Both ports acknowledged in the same cycle");

    // Single-cycle commands answer on the next edge
    assert property (@(posedge clk) disable iff (srst)
        (req_hi.req && rdy_hi && (req_hi.command != db_pkg::COMMAND_CLEAR)) |=> resp_hi.ack)
        else $error("High port request accepted but not acknowledged one cycle later");

    assert property (@(posedge clk) disable iff (srst)
        (req_lo.req && rdy_lo && (req_lo.command != db_pkg::COMMAND_CLEAR)) |=> resp_lo.ack)
        else $error("Low port request accepted but not acknowledged one cycle later");

    assert property (@(posedge clk) disable iff (srst)
        (rdy_hi || rdy_lo) |-> store_rdy)
        else $error("Port ready while the store is busy");

    // No stale ack out of reset
    assert property (@(posedge clk)
        srst |=> !store_resp.ack)
        else $error("Ack high in the cycle after reset");

endmodule : db_assert

bind db_top db_assert i_assert (
    .clk        ( clk ),
    .srst       ( srst ),
    .req_hi     ( req_hi ),
    .req_lo     ( req_lo ),
    .rdy_hi     ( rdy_hi ),
    .rdy_lo     ( rdy_lo ),
    .resp_hi    ( resp_hi ),
    .resp_lo    ( resp_lo ),
    .store_rdy  ( store_rdy ),
    .store_resp ( store_resp )
);

`default_nettype wire

/* sim/db_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kv_db_config.svh"

module db_tb;

    // ==============================
    // Timing and run length
    // ==============================

    localparam int CLK_PERIOD = 20;
    localparam int NUM_KEYS   = 16;
    localparam int CLEAR_LAT  = `KV_DB_DEPTH + 1;
    // Transactions over all tests, each done within four cycles
    localparam int NUM_TRANS  = 120;
    // Reset, power-up wipe, one CLEAR walk and all transactions
    localparam int RUN_CYCLES = 3 + `KV_DB_DEPTH + CLEAR_LAT + 4 * NUM_TRANS;

    logic             clk;
    logic             srst;
    db_pkg::db_req_t  req_hi;
    db_pkg::db_req_t  req_lo;
    logic             rdy_hi;
    logic             rdy_lo;
    db_pkg::db_resp_t resp_hi;
    db_pkg::db_resp_t resp_lo;

    // Reference copy of the table
    logic                      ref_valid [`KV_DB_DEPTH];
    logic [`KV_DB_VALUE_W-1:0] ref_value [`KV_DB_DEPTH];
    logic [`KV_DB_KEY_W-1:0]   keys [NUM_KEYS];

    db_top i_dut (
        .clk     ( clk ),
        .srst    ( srst ),
        .req_hi  ( req_hi ),
        .rdy_hi  ( rdy_hi ),
        .resp_hi ( resp_hi ),
        .req_lo  ( req_lo ),
        .rdy_lo  ( rdy_lo ),
        .resp_lo ( resp_lo )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Twice the expected run length
    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation timed out");
    end

    // ==============================
    // Checks and reference model
    // ==============================

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s: expected %0h actual %0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Compare one ack against the model, then apply the command to the model
    task automatic check_response(input string name, input db_pkg::command_t req_cmd,
                                  input logic [`KV_DB_KEY_W-1:0] req_key,
                                  input logic [`KV_DB_VALUE_W-1:0] req_value,
                                  input int latency, input db_pkg::db_resp_t resp);
        db_pkg::status_t exp_status;
        int              exp_latency;

        exp_status  = (req_cmd == db_pkg::COMMAND_NOP) ? db_pkg::STATUS_ERROR
                                                       : db_pkg::STATUS_OK;
        exp_latency = (req_cmd == db_pkg::COMMAND_CLEAR) ? CLEAR_LAT : 1;
        check_equal({name, "_status"}, 32'(exp_status), 32'(resp.status));
        check_equal({name, "_latency"}, exp_latency, latency);
        case (req_cmd)
            db_pkg::COMMAND_GET: begin
                check_equal({name, "_valid"}, 32'(ref_valid[req_key]), 32'(resp.valid));
                check_equal({name, "_value"}, ref_valid[req_key] ? ref_value[req_key] : '0,
                            resp.get_value);
            end
            db_pkg::COMMAND_SET: begin
                ref_valid[req_key] = 1'b1;
                ref_value[req_key] = req_value;
            end
            db_pkg::COMMAND_UNSET: begin
                ref_valid[req_key] = 1'b0;
            end
            db_pkg::COMMAND_CLEAR: begin
                foreach (ref_valid[i]) begin
                    ref_valid[i] = 1'b0;
                end
            end
            default: begin
            end
        endcase
    endtask

    function automatic logic [`KV_DB_KEY_W-1:0] random_key();
        logic [31:0] draw;

        draw = $urandom();
        return draw[`KV_DB_KEY_W-1:0];
    endfunction

    // ==============================
    // Port drivers
    // ==============================

    task automatic hi_request(input string name, input db_pkg::command_t req_cmd,
                              input logic [`KV_DB_KEY_W-1:0] req_key,
                              input logic [`KV_DB_VALUE_W-1:0] req_value,
                              output time ack_time);
        int latency;

        @(posedge clk);
        req_hi <= '{req: 1'b1, command: req_cmd, key: req_key, set_value: req_value};
        // Held until the edge that sees rdy
        do begin
            @(posedge clk);
        end while (!rdy_hi);
        req_hi.req <= 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!resp_hi.ack);
        ack_time = $time;
        check_response(name, req_cmd, req_key, req_value, latency, resp_hi);
    endtask

    task automatic lo_request(input string name, input db_pkg::command_t req_cmd,
                              input logic [`KV_DB_KEY_W-1:0] req_key,
                              input logic [`KV_DB_VALUE_W-1:0] req_value,
                              output time ack_time);
        int latency;

        @(posedge clk);
        req_lo <= '{req: 1'b1, command: req_cmd, key: req_key, set_value: req_value};
        do begin
            @(posedge clk);
        end while (!rdy_lo);
        req_lo.req <= 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!resp_lo.ack);
        ack_time = $time;
        check_response(name, req_cmd, req_key, req_value, latency, resp_lo);
    endtask

    task automatic reset_and_wait();
        repeat (3) @(posedge clk);
        srst <= 1'b0;
        // With no request pending the selection rests on the low port
        do begin
            @(posedge clk);
        end while (!(rdy_hi || rdy_lo));
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        time hi_done;
        time lo_done;

        clk    = 1'b0;
        srst   = 1'b1;
        req_hi = '0;
        req_lo = '0;
        foreach (ref_valid[i]) begin
            ref_valid[i] = 1'b0;
        end
        void'($urandom(32'h5797e1f3));
        reset_and_wait();

        // Fresh table reads back empty
        for (int i = 0; i < 8; i++) begin
            hi_request("get_empty", db_pkg::COMMAND_GET, random_key(), '0, hi_done);
        end

        // SET then GET
        for (int i = 0; i < NUM_KEYS; i++) begin
            keys[i] = random_key();
            hi_request("set", db_pkg::COMMAND_SET, keys[i], $urandom(), hi_done);
        end
        for (int i = 0; i < NUM_KEYS; i++) begin
            lo_request("get_key", db_pkg::COMMAND_GET, keys[i], '0, lo_done);
        end

        // UNSET a few keys, the rest keep their values
        for (int i = 0; i < 4; i++) begin
            hi_request("unset", db_pkg::COMMAND_UNSET, keys[i], '0, hi_done);
        end
        for (int i = 0; i < NUM_KEYS; i++) begin
            hi_request("get_after_unset", db_pkg::COMMAND_GET, keys[i], '0, hi_done);
        end

        // NOP answers ERROR and writes nothing
        for (int i = 0; i < 4; i++) begin
            lo_request("nop", db_pkg::COMMAND_NOP, keys[i + 4], $urandom(), lo_done);
        end
        for (int i = 0; i < NUM_KEYS; i++) begin
            hi_request("get_after_nop", db_pkg::COMMAND_GET, keys[i], '0, hi_done);
        end

        // Both ports in the same cycle, high port first
        for (int i = 0; i < 4; i++) begin
            fork
                hi_request("race_set_hi", db_pkg::COMMAND_SET, keys[i], $urandom(), hi_done);
                lo_request("race_get_lo", db_pkg::COMMAND_GET, keys[i], '0, lo_done);
            join
            check_equal("race_order", 32'd1, 32'(lo_done > hi_done));
            fork
                lo_request("race_set_lo", db_pkg::COMMAND_SET, keys[i + 4], $urandom(),
                           lo_done);
                hi_request("race_get_hi", db_pkg::COMMAND_GET, keys[i + 4], '0, hi_done);
            join
            check_equal("race_order", 32'd1, 32'(lo_done > hi_done));
        end

        // CLEAR walk, then every key is empty
        hi_request("clear", db_pkg::COMMAND_CLEAR, random_key(), '0, hi_done);
        for (int i = 0; i < NUM_KEYS; i++) begin
            lo_request("get_after_clear", db_pkg::COMMAND_GET, keys[i], '0, lo_done);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : db_tb

`default_nettype wire
